/* rtl/bp_config.svh */
`ifndef BP_CONFIG_SVH
`define BP_CONFIG_SVH

// ============================================================
// Branch predictor sizing
// ============================================================

// Counter table, indexed by PC[BP_BHT_INDEX_BITS+1:2]
`define BP_BHT_INDEX_BITS 10
`define BP_BHT_ENTRIES    (1 << `BP_BHT_INDEX_BITS)

// Target buffer, direct mapped
`define BP_BTB_INDEX_BITS 8
`define BP_BTB_ENTRIES    (1 << `BP_BTB_INDEX_BITS)

// PC bits kept above the BTB index
`define BP_TAG_BITS       12

// Weakly not taken
`define BP_CTR_RESET      2'b01

`endif

/* rtl/bp_pkg.sv */
`default_nettype none

`include "bp_config.svh"

package bp_pkg;

  // ============================================================
  // PC slicing shared by lookup and update paths
  // ============================================================

  function automatic logic [`BP_BHT_INDEX_BITS-1:0] bht_index_of(input logic [31:0] pc);
    return pc[`BP_BHT_INDEX_BITS+1:2]; // Skip halfword/byte alignment bits
  endfunction

  function automatic logic [`BP_BTB_INDEX_BITS-1:0] btb_index_of(input logic [31:0] pc);
    return pc[`BP_BTB_INDEX_BITS+1:2];
  endfunction

  function automatic logic [`BP_TAG_BITS-1:0] btb_tag_of(input logic [31:0] pc);
    return pc[`BP_BTB_INDEX_BITS+`BP_TAG_BITS+1:`BP_BTB_INDEX_BITS+2];
  endfunction

  // ============================================================
  // 2-bit saturating counter step
  // ============================================================

  function automatic logic [1:0] ctr_next(input logic [1:0] ctr, input logic taken);
    logic [1:0] nxt;
    case (ctr)
      2'b00:   nxt = taken ? 2'b01 : 2'b00;
      2'b01:   nxt = taken ? 2'b10 : 2'b00;
      2'b10:   nxt = taken ? 2'b11 : 2'b01;
      default: nxt = taken ? 2'b11 : 2'b10; // Strongly taken holds at 3
    endcase
    return nxt;
  endfunction

endpackage

`default_nettype wire

/* rtl/bp_ifs.sv */
`timescale 1ns/1ns
`default_nettype none

`include "bp_config.svh"

// Counter table: one lookup port, one update port
interface bht_if;

  logic [`BP_BHT_INDEX_BITS-1:0] rd_index;
  logic [1:0]                    rd_ctr;

  logic                          upd_en;
  logic [`BP_BHT_INDEX_BITS-1:0] upd_index;
  logic                          upd_taken;

  modport master (
    output rd_index,
    input  rd_ctr,
    output upd_en,
    output upd_index,
    output upd_taken
  );

  modport tbl (
    input  rd_index,
    output rd_ctr,
    input  upd_en,
    input  upd_index,
    input  upd_taken
  );

endinterface

// Target buffer: tagged lookup and allocate/overwrite port
interface btb_if;

  logic [`BP_BTB_INDEX_BITS-1:0] lu_index;
  logic [`BP_TAG_BITS-1:0]       lu_tag;
  logic                          lu_hit;
  logic [31:0]                   lu_target;

  logic                          wr_en;
  logic [`BP_BTB_INDEX_BITS-1:0] wr_index;
  logic [`BP_TAG_BITS-1:0]       wr_tag;
  logic [31:0]                   wr_target;

  modport master (
    output lu_index, lu_tag,
    input  lu_hit, lu_target,
    output wr_en, wr_index, wr_tag, wr_target
  );

  modport tbl (
    input  lu_index, lu_tag,
    output lu_hit, lu_target,
    input  wr_en, wr_index, wr_tag, wr_target
  );

endinterface

`default_nettype wire

/* rtl/bp_bht.sv */
`timescale 1ns/1ns
`default_nettype none

`include "bp_config.svh"

module bp_bht (
  input  logic clk,
  input  logic rst_n,
  bht_if.tbl   bht
);

  logic [1:0] ctr_q [`BP_BHT_ENTRIES];
  logic [1:0] upd_old;
  logic [1:0] upd_new;

  // ============================================================
  // Read port
  // ============================================================

  assign bht.rd_ctr = ctr_q[bht.rd_index]; // Old value on same-cycle update

  // ============================================================
  // Read-modify-write update
  // ============================================================

  assign upd_old = ctr_q[bht.upd_index];
  assign upd_new = bp_pkg::ctr_next(upd_old, bht.upd_taken);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `BP_BHT_ENTRIES; i++) begin
        ctr_q[i] <= `BP_CTR_RESET;
      end
    end else if (bht.upd_en) begin
      ctr_q[bht.upd_index] <= upd_new;
    end
  end

  // Update address must be clean whenever an update is strobed from ctrl
  a_upd_index_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    bht.upd_en |-> !$isunknown(bht.upd_index)
  ) else $error("BHT update index has X/Z bits");

endmodule

`default_nettype wire

/* rtl/bp_btb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "bp_config.svh"

module bp_btb (
  input  logic clk,
  input  logic rst_n,
  btb_if.tbl   btb
);

  logic [`BP_BTB_ENTRIES-1:0] valid_q;
  logic [`BP_TAG_BITS-1:0]    tag_q    [`BP_BTB_ENTRIES];
  logic [31:0]                target_q [`BP_BTB_ENTRIES];

  logic                       lu_valid;
  logic                       lu_tag_match;

  // ============================================================
  // Lookup
  // ============================================================

  assign lu_valid     = valid_q[btb.lu_index];
  assign lu_tag_match = (tag_q[btb.lu_index] == btb.lu_tag);

  assign btb.lu_hit    = lu_valid & lu_tag_match;
  assign btb.lu_target = target_q[btb.lu_index];

  // ============================================================
  // Allocate / overwrite
  // ============================================================

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (btb.wr_en) begin
      valid_q[btb.wr_index] <= 1'b1;
    end
  end

  // Payload only, qualified by valid_q
  always_ff @(posedge clk) begin
    if (btb.wr_en) begin
      tag_q[btb.wr_index]    <= btb.wr_tag;
      target_q[btb.wr_index] <= btb.wr_target;
    end
  end

  // Written entry must hit with its new target on the next cycle
  a_write_then_hit: assert property (
    @(posedge clk) disable iff (!rst_n)
    btb.wr_en |=> ((btb.lu_index != $past(btb.wr_index)) ||
                   (btb.lu_tag != $past(btb.wr_tag)) ||
                   (btb.lu_hit && (btb.lu_target == $past(btb.wr_target))))
  ) else $error("BTB entry not readable after write");

endmodule

`default_nettype wire

/* rtl/bp_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module bp_ctrl (
  input  logic        clk,
  input  logic        rst_n,

  input  logic        fetch_valid,
  input  logic [31:0] fetch_pc,

  input  logic        resolve_valid,
  input  logic        resolve_taken,
  input  logic [31:0] resolve_pc,
  input  logic [31:0] resolve_target,

  bht_if.master       bht,
  btb_if.master       btb,

  output logic        pred_hit,
  output logic        pred_taken,
  output logic [31:0] pred_next_pc
);

  logic        valid_hit;
  logic        ctr_says_taken;
  logic [31:0] seq_pc;

  // ============================================================
  // Lookup side, fully combinational
  // ============================================================

  always_comb begin
    bht.rd_index = bp_pkg::bht_index_of(fetch_pc);
    btb.lu_index = bp_pkg::btb_index_of(fetch_pc);
    btb.lu_tag   = bp_pkg::btb_tag_of(fetch_pc);
  end

  assign valid_hit      = fetch_valid & btb.lu_hit;
  assign ctr_says_taken = bht.rd_ctr[1]; // Upper bit set means taken
  assign seq_pc         = fetch_pc + 32'd4;

  assign pred_hit     = valid_hit;
  assign pred_taken   = fetch_valid & btb.lu_hit & ctr_says_taken;
  assign pred_next_pc = (valid_hit && ctr_says_taken) ? btb.lu_target : seq_pc;

  // ============================================================
  // Update side
  // ============================================================

  always_comb begin
    bht.upd_en    = resolve_valid; // Every resolved branch trains its counter
    bht.upd_index = bp_pkg::bht_index_of(resolve_pc);
    bht.upd_taken = resolve_taken;
  end

  // Not-taken branches never allocate a target entry
  always_comb begin
    btb.wr_en     = resolve_valid & resolve_taken;
    btb.wr_index  = bp_pkg::btb_index_of(resolve_pc);
    btb.wr_tag    = bp_pkg::btb_tag_of(resolve_pc);
    btb.wr_target = resolve_target;
  end

  // A taken resolution makes the same PC hit on the following fetch
  a_taken_resolve_hits: assert property (
    @(posedge clk) disable iff (!rst_n)
    (resolve_valid && resolve_taken) |=>
      (!(fetch_valid && (fetch_pc == $past(resolve_pc))) || pred_hit)
  ) else $error("taken branch did not hit on the next lookup of its PC");

endmodule

`default_nettype wire

/* rtl/bp_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module bp_unit (
  input  logic        clk,
  input  logic        rst_n,

  // Fetch lookup
  input  logic        fetch_valid,
  input  logic [31:0] fetch_pc,

  // Execute resolution
  input  logic        resolve_valid,
  input  logic [31:0] resolve_pc,
  input  logic        resolve_taken,
  input  logic [31:0] resolve_target,

  // Prediction, same cycle as fetch_pc
  output logic        pred_hit,
  output logic        pred_taken,
  output logic [31:0] pred_next_pc
);

  bht_if bht_bus ();
  btb_if btb_bus ();

  bp_ctrl u_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_valid    (fetch_valid),
    .fetch_pc       (fetch_pc),
    .resolve_valid  (resolve_valid),
    .resolve_taken  (resolve_taken),
    .resolve_pc     (resolve_pc),
    .resolve_target (resolve_target),
    .bht            (bht_bus.master),
    .btb            (btb_bus.master),
    .pred_hit       (pred_hit),
    .pred_taken     (pred_taken),
    .pred_next_pc   (pred_next_pc)
  );

  bp_bht u_bht (
    .clk   (clk),
    .rst_n (rst_n),
    .bht   (bht_bus.tbl)
  );

  bp_btb u_btb (
    .clk   (clk),
    .rst_n (rst_n),
    .btb   (btb_bus.tbl)
  );

endmodule

`default_nettype wire

/* verif/bp_unit_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "bp_config.svh"

module bp_unit_tb;

  localparam int MAX_CYCLES    = 5000;
  localparam int RANDOM_CYCLES = 2000;

  // Directed PCs: PC_B shares the BTB index of PC_A with another tag
  localparam logic [31:0] PC_N  = 32'h0000_3F08;
  localparam logic [31:0] PC_A  = 32'h0000_1040;
  localparam logic [31:0] PC_B  = 32'h0000_1440;
  localparam logic [31:0] TGT_A = 32'h0000_8000;
  localparam logic [31:0] TGT_B = 32'h0000_9A10;
  localparam logic [31:0] TGT_C = 32'h0001_0F0C;

  logic        clk;
  logic        rst_n;
  logic        fetch_valid;
  logic [31:0] fetch_pc;
  logic        resolve_valid;
  logic [31:0] resolve_pc;
  logic        resolve_taken;
  logic [31:0] resolve_target;
  logic        pred_hit;
  logic        pred_taken;
  logic [31:0] pred_next_pc;

  // Reference model state
  logic [1:0]              ctr_m    [`BP_BHT_ENTRIES];
  logic                    valid_m  [`BP_BTB_ENTRIES];
  logic [`BP_TAG_BITS-1:0] tag_m    [`BP_BTB_ENTRIES];
  logic [31:0]             target_m [`BP_BTB_ENTRIES];

  int cycle_count = 0;

  bp_unit UUT (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_valid    (fetch_valid),
    .fetch_pc       (fetch_pc),
    .resolve_valid  (resolve_valid),
    .resolve_pc     (resolve_pc),
    .resolve_taken  (resolve_taken),
    .resolve_target (resolve_target),
    .pred_hit       (pred_hit),
    .pred_taken     (pred_taken),
    .pred_next_pc   (pred_next_pc)
  );

  always #50 clk = ~clk;

  // ============================================================
  // Reference model
  // ============================================================

  function automatic logic [1:0] next_count(input logic [1:0] ctr, input logic taken);
    if (taken) begin
      return (ctr == 2'd3) ? ctr : ctr + 2'd1;
    end else begin
      return (ctr == 2'd0) ? ctr : ctr - 2'd1;
    end
  endfunction

  // Returns {hit, taken, next_pc} from the state before this cycle's update
  function automatic logic [33:0] expected_prediction(input logic fv, input logic [31:0] pc);
    int unsigned             bi;
    int unsigned             ti;
    logic [`BP_TAG_BITS-1:0] tg;
    logic                    hit;
    logic                    taken;
    logic [31:0]             next_pc;
    bi      = (pc >> 2) % `BP_BHT_ENTRIES;
    ti      = (pc >> 2) % `BP_BTB_ENTRIES;
    tg      = `BP_TAG_BITS'(pc >> (`BP_BTB_INDEX_BITS + 2));
    hit     = fv && valid_m[ti] && (tag_m[ti] == tg);
    taken   = hit && (ctr_m[bi] >= 2'd2);
    next_pc = taken ? target_m[ti] : pc + 32'd4;
    return {hit, taken, next_pc};
  endfunction

  task automatic model_reset();
    for (int i = 0; i < `BP_BHT_ENTRIES; i++) begin
      ctr_m[i] = `BP_CTR_RESET;
    end
    for (int i = 0; i < `BP_BTB_ENTRIES; i++) begin
      valid_m[i] = 1'b0;
    end
  endtask

  task automatic model_update(input logic [31:0] pc, input logic taken, input logic [31:0] tgt);
    int unsigned bi;
    int unsigned ti;
    bi        = (pc >> 2) % `BP_BHT_ENTRIES;
    ti        = (pc >> 2) % `BP_BTB_ENTRIES;
    ctr_m[bi] = next_count(ctr_m[bi], taken);
    if (taken) begin // Only taken branches allocate
      valid_m[ti]  = 1'b1;
      tag_m[ti]    = `BP_TAG_BITS'(pc >> (`BP_BTB_INDEX_BITS + 2));
      target_m[ti] = tgt;
    end
  endtask

  task automatic end_with_failure(input string what);
    $display("%s", what);
    $display("Test failed");
    $fatal(1);
  endtask

  // ============================================================
  // Comparison and run limit
  // ============================================================

  always @(posedge clk) begin
    logic [33:0] exp_pred;
    if (!rst_n) begin
      model_reset();
    end else begin
      exp_pred = expected_prediction(fetch_valid, fetch_pc);
      assert (pred_hit === exp_pred[33])
        else end_with_failure($sformatf("mismatch pred_hit: got %h, expected %h",
                                        pred_hit, exp_pred[33]));
      assert (pred_taken === exp_pred[32])
        else end_with_failure($sformatf("mismatch pred_taken: got %h, expected %h",
                                        pred_taken, exp_pred[32]));
      assert (pred_next_pc === exp_pred[31:0])
        else end_with_failure($sformatf("mismatch pred_next_pc: got %h, expected %h",
                                        pred_next_pc, exp_pred[31:0]));
      if (resolve_valid) begin
        model_update(resolve_pc, resolve_taken, resolve_target);
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      end_with_failure("timeout: the run went past its cycle limit");
    end
  end

  // ============================================================
  // Stimulus
  // ============================================================

  task automatic drive_cycle(input logic fv, input logic [31:0] fpc, input logic rv,
                             input logic [31:0] rpc, input logic rt, input logic [31:0] rtgt);
    @(negedge clk);
    fetch_valid    = fv;
    fetch_pc       = fpc;
    resolve_valid  = rv;
    resolve_pc     = rpc;
    resolve_taken  = rt;
    resolve_target = rtgt;
  endtask

  task automatic lookup_only(input logic [31:0] pc);
    drive_cycle(1'b1, pc, 1'b0, 32'h0, 1'b0, 32'h0);
  endtask

  task automatic lookup_and_resolve(input logic [31:0] pc, input logic taken,
                                    input logic [31:0] tgt);
    drive_cycle(1'b1, pc, 1'b1, pc, taken, tgt);
  endtask

  initial begin
    logic [31:0] pool [8];
    logic [31:0] rand_word;
    logic [2:0]  sel_f;
    logic [2:0]  sel_r;
    logic        fv_r;
    logic        rv_r;
    logic        rt_r;
    void'($urandom(32'h4278));
    clk            = 1'b0;
    rst_n          = 1'b0;
    fetch_valid    = 1'b0;
    fetch_pc       = 32'h0;
    resolve_valid  = 1'b0;
    resolve_pc     = 32'h0;
    resolve_taken  = 1'b0;
    resolve_target = 32'h0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;

    for (int i = 0; i < 6; i++) begin // Cold lookups all miss
      rand_word = $urandom;
      lookup_only(rand_word);
    end

    repeat (3) lookup_and_resolve(PC_N, 1'b0, TGT_A); // Not taken, no allocation
    lookup_only(PC_N);

    lookup_and_resolve(PC_A, 1'b1, TGT_A); // Allocates, same-cycle lookup still misses
    lookup_only(PC_A);
    repeat (3) lookup_and_resolve(PC_A, 1'b1, TGT_A); // Saturate at 3
    lookup_only(PC_A);
    repeat (2) lookup_and_resolve(PC_A, 1'b0, TGT_A); // Back to weakly not taken
    lookup_only(PC_A);

    lookup_only(PC_B); // Same index, other tag
    lookup_and_resolve(PC_B, 1'b1, TGT_B);
    lookup_only(PC_A);
    lookup_only(PC_B);

    drive_cycle(1'b0, PC_B, 1'b0, 32'h0, 1'b0, 32'h0); // Gated by fetch_valid
    lookup_and_resolve(PC_B, 1'b1, TGT_C); // Old target seen this cycle
    lookup_only(PC_B);

    // ============================================================
    // Random mix over a small aliasing pool
    // ============================================================
    for (int i = 0; i < 8; i++) begin
      pool[i] = 32'h0000_2000 + 32'(i % 4) * 32'd4 + 32'(i / 4) * 32'h400;
    end
    for (int n = 0; n < RANDOM_CYCLES; n++) begin
      sel_f     = 3'($urandom);
      sel_r     = 3'($urandom);
      fv_r      = ($urandom % 4) != 0;
      rv_r      = 1'($urandom);
      rt_r      = 1'($urandom);
      rand_word = $urandom;
      drive_cycle(fv_r, pool[sel_f], rv_r, pool[sel_r], rt_r, {rand_word[31:2], 2'b00});
    end

    drive_cycle(1'b0, 32'h0, 1'b0, 32'h0, 1'b0, 32'h0);
    @(posedge clk);
    #1;
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+rtl
rtl/bp_pkg.sv
rtl/bp_ifs.sv
rtl/bp_bht.sv
rtl/bp_btb.sv
rtl/bp_ctrl.sv
rtl/bp_unit.sv
verif/bp_unit_tb.sv

/* Makefile */
SIM := obj_dir/Vbp_unit_tb

.PHONY: all run clean

all: run

$(SIM): tb.f rtl/bp_config.svh rtl/bp_pkg.sv rtl/bp_ifs.sv rtl/bp_bht.sv \
        rtl/bp_btb.sv rtl/bp_ctrl.sv rtl/bp_unit.sv verif/bp_unit_tb.sv
	verilator --binary --timing --assert -j 0 --top-module bp_unit_tb -f tb.f

run: $(SIM)
	$(SIM) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Test failed" sim.log; then \
	  echo "Simulation reported failure"; exit 1; \
	elif ! grep -q "Test passed" sim.log; then \
	  echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
